//--- all.f
+incdir+rtl
rtl/spi_cfg_pkg.sv
rtl/spi_stream_pkg.sv
rtl/stream_reg_slice.sv
rtl/spi_sclk_gen.sv
rtl/spi_shifter.sv
rtl/spi_xfer_ctrl.sv
rtl/spi_master_top.sv
verification/spi_master_props.sv
verification/spi_master_tb.sv

//--- rtl/spi_cfg_pkg.sv
// Static SPI configuration struct and SPI pin bundle

`include "spi_defs.svh"

package spi_cfg_pkg;

    // Static settings, held steady while a transfer runs
    typedef struct packed {
        logic                        cpol;
        logic                        cpha;
        // System clocks per SCLK period, even, 4 or more
        logic [`SPI_DIV_WIDTH-1:0]   divider;
        // Idle system clocks after a packet, 1 or more
        logic [`SPI_WAIT_WIDTH-1:0]  wait_time;
        logic [`SPI_ADDR_WIDTH-1:0]  addr;
    } spi_cfg_t;

    // Outgoing SPI pins, chip selects active low
    typedef struct packed {
        logic                        sclk;
        logic                        mosi;
        logic [`SPI_SLAVE_NUM-1:0]   cs_n;
    } spi_pins_t;

endpackage

//--- rtl/spi_defs.svh
// Width and count macros shared by the SPI master RTL and testbench

`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// Bits shifted per stream beat
`define SPI_DATA_WIDTH 8

// System clock divider counter
`define SPI_DIV_WIDTH 16

// Post-packet idle counter
`define SPI_WAIT_WIDTH 16

// Chip selects and the address that picks one
`define SPI_SLAVE_NUM 4
`define SPI_ADDR_WIDTH $clog2(`SPI_SLAVE_NUM)

`endif

//--- rtl/spi_master_top.sv
// SPI master top level with stream register slices on both sides

`timescale 1ns/1ns

`include "spi_defs.svh"

module spi_master_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,

    input  logic                        s_valid_i,
    input  spi_stream_pkg::tx_beat_t    s_beat_i,
    output logic                        s_ready_o,

    output logic                        m_valid_o,
    output spi_stream_pkg::rx_beat_t    m_beat_o,
    input  logic                        m_ready_i,

    input  spi_cfg_pkg::spi_cfg_t       cfg_i,
    output spi_cfg_pkg::spi_pins_t      spi_o,
    input  logic                        miso_i
);

    import spi_stream_pkg::*;

    logic                       tx_valid;
    logic                       tx_ready;
    tx_beat_t                   tx_beat;
    logic                       rx_valid;
    logic                       rx_ready;
    rx_beat_t                   rx_beat;

    logic                       start;
    logic                       done;
    logic [`SPI_DATA_WIDTH-1:0] tx_data;
    logic [`SPI_DATA_WIDTH-1:0] rx_data;
    edge_t                      edges;
    logic                       sclk;
    logic                       mosi;
    logic [`SPI_SLAVE_NUM-1:0]  cs_n;

    // --------------------
    // Stream slices
    // --------------------
    stream_reg_slice #(.payload_t(tx_beat_t)) u_tx_slice (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (s_valid_i),
        .in_data_i   (s_beat_i),
        .in_ready_o  (s_ready_o),
        .out_valid_o (tx_valid),
        .out_data_o  (tx_beat),
        .out_ready_i (tx_ready)
    );

    stream_reg_slice #(.payload_t(rx_beat_t)) u_rx_slice (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (rx_valid),
        .in_data_i   (rx_beat),
        .in_ready_o  (rx_ready),
        .out_valid_o (m_valid_o),
        .out_data_o  (m_beat_o),
        .out_ready_i (m_ready_i)
    );

    // --------------------
    // Transfer engine
    // --------------------
    spi_xfer_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_i       (cfg_i),
        .in_valid_i  (tx_valid),
        .in_beat_i   (tx_beat),
        .in_ready_o  (tx_ready),
        .start_o     (start),
        .tx_data_o   (tx_data),
        .sclk_done_i (done),
        .rx_data_i   (rx_data),
        .cs_n_o      (cs_n),
        .out_valid_o (rx_valid),
        .out_beat_o  (rx_beat),
        .out_ready_i (rx_ready)
    );

    spi_sclk_gen u_sclk_gen (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .start_i   (start),
        .cpol_i    (cfg_i.cpol),
        .divider_i (cfg_i.divider),
        .sclk_o    (sclk),
        .edge_o    (edges),
        .done_o    (done)
    );

    spi_shifter u_shifter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .start_i   (start),
        .tx_data_i (tx_data),
        .cpha_i    (cfg_i.cpha),
        .edge_i    (edges),
        .miso_i    (miso_i),
        .mosi_o    (mosi),
        .rx_data_o (rx_data)
    );

    assign spi_o = '{sclk: sclk, mosi: mosi, cs_n: cs_n};

endmodule

//--- rtl/spi_sclk_gen.sv
// SCLK divider, edge counter, SCLK register and edge pulse generation

`timescale 1ns/1ns

`include "spi_defs.svh"

module spi_sclk_gen (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        start_i,
    input  logic                        cpol_i,
    input  logic [`SPI_DIV_WIDTH-1:0]   divider_i,
    output logic                        sclk_o,
    output spi_stream_pkg::edge_t       edge_o,
    output logic                        done_o
);

    localparam int EDGE_NUM = 2 * `SPI_DATA_WIDTH;
    localparam int EDGE_W   = $clog2(EDGE_NUM) + 1;

    logic                       busy;
    logic [`SPI_DIV_WIDTH-1:0]  clk_cnt;
    logic [EDGE_W-1:0]          edge_cnt;
    logic                       half_hit;
    logic                       full_hit;

    // Leading toggle at half period, trailing toggle at full period
    assign half_hit = (clk_cnt == (divider_i >> 1) - 1'b1);
    assign full_hit = (clk_cnt == divider_i - 1'b1);

    // --------------------
    // Divider and edges
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy     <= 1'b0;
            clk_cnt  <= '0;
            edge_cnt <= '0;
            sclk_o   <= cpol_i;
            edge_o   <= '0;
        end else begin
            edge_o <= '0;
            if (start_i) begin
                busy     <= 1'b1;
                clk_cnt  <= '0;
                edge_cnt <= '0;
            end else if (busy) begin
                if (full_hit) begin
                    clk_cnt <= '0;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                if (half_hit || full_hit) begin
                    sclk_o          <= ~sclk_o;
                    edge_cnt        <= edge_cnt + 1'b1;
                    edge_o.leading  <= half_hit;
                    edge_o.trailing <= full_hit;
                    // Final trailing toggle ends the beat
                    if (edge_cnt == EDGE_W'(EDGE_NUM - 1)) begin
                        busy <= 1'b0;
                    end
                end
            end else begin
                sclk_o <= cpol_i;
            end
        end
    end

    // --------------------
    // Done pulse
    // --------------------

    // One cycle after the final edge so the last MISO sample is stored
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= edge_o.trailing & (edge_cnt == EDGE_W'(EDGE_NUM));
        end
    end

endmodule

//--- rtl/spi_shifter.sv
// MOSI transmit shift register and MISO receive shift register

`timescale 1ns/1ns

`include "spi_defs.svh"

module spi_shifter (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        start_i,
    input  logic [`SPI_DATA_WIDTH-1:0]  tx_data_i,
    input  logic                        cpha_i,
    input  spi_stream_pkg::edge_t       edge_i,
    input  logic                        miso_i,
    output logic                        mosi_o,
    output logic [`SPI_DATA_WIDTH-1:0]  rx_data_o
);

    localparam int DW = `SPI_DATA_WIDTH;

    logic [DW-1:0] tx_sreg;
    logic [DW-1:0] rx_sreg;
    logic          shift_edge;
    logic          sample_edge;

    // cpha 0 drives on trailing and samples on leading, cpha 1 the reverse
    assign shift_edge  = cpha_i ? edge_i.leading : edge_i.trailing;
    assign sample_edge = cpha_i ? edge_i.trailing : edge_i.leading;

    // --------------------
    // Transmit, MSB first
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mosi_o <= 1'b0;
        end else if (start_i) begin
            // cpha 0 needs the MSB on the line before the first edge
            if (!cpha_i) begin
                mosi_o <= tx_data_i[DW-1];
            end
        end else if (shift_edge) begin
            mosi_o <= tx_sreg[DW-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            if (cpha_i) begin
                tx_sreg <= tx_data_i;
            end else begin
                tx_sreg <= {tx_data_i[DW-2:0], 1'b0};
            end
        end else if (shift_edge) begin
            tx_sreg <= {tx_sreg[DW-2:0], 1'b0};
        end
    end

    // --------------------
    // Receive
    // --------------------
    always_ff @(posedge clk_i) begin
        if (sample_edge) begin
            rx_sreg <= {rx_sreg[DW-2:0], miso_i};
        end
    end

    assign rx_data_o = rx_sreg;

endmodule

//--- rtl/spi_stream_pkg.sv
// Stream beat structs and the SCLK edge pulse struct

`include "spi_defs.svh"

package spi_stream_pkg;

    // --------------------
    // Stream payloads
    // --------------------

    // Word to send, last closes the packet
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;
        logic                       last;
    } tx_beat_t;

    // Word captured from MISO, last copied from the sent beat
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;
        logic                       last;
    } rx_beat_t;

    // --------------------
    // Internal pulses
    // --------------------

    // One-cycle markers of SCLK toggles within a period
    typedef struct packed {
        logic leading;
        logic trailing;
    } edge_t;

endpackage

//--- rtl/spi_xfer_ctrl.sv
// Transfer FSM, post-packet wait counter, chip-select decode, receive beat

`timescale 1ns/1ns

`include "spi_defs.svh"

module spi_xfer_ctrl (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  spi_cfg_pkg::spi_cfg_t       cfg_i,

    input  logic                        in_valid_i,
    input  spi_stream_pkg::tx_beat_t    in_beat_i,
    output logic                        in_ready_o,

    output logic                        start_o,
    output logic [`SPI_DATA_WIDTH-1:0]  tx_data_o,
    input  logic                        sclk_done_i,
    input  logic [`SPI_DATA_WIDTH-1:0]  rx_data_i,
    output logic [`SPI_SLAVE_NUM-1:0]   cs_n_o,

    output logic                        out_valid_o,
    output spi_stream_pkg::rx_beat_t    out_beat_o,
    input  logic                        out_ready_i
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        DATA = 2'b01,
        WAIT = 2'b10
    } state_e;

    state_e                     state;
    logic                       cs_active;
    logic                       last_q;
    logic [`SPI_WAIT_WIDTH-1:0] wait_cnt;
    logic                       wait_done;
    logic                       accept;

    // Only take a beat when its result has somewhere to go
    assign in_ready_o = (state == IDLE) & ~out_valid_o & out_ready_i;
    assign accept     = in_valid_i & in_ready_o;
    assign wait_done  = (wait_cnt == cfg_i.wait_time - 1'b1);

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= IDLE;
            cs_active <= 1'b0;
            last_q    <= 1'b0;
            start_o   <= 1'b0;
            wait_cnt  <= '0;
        end else begin
            start_o <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= DATA;
                        cs_active <= 1'b1;
                        last_q    <= in_beat_i.last;
                    end
                end
                DATA: begin
                    if (sclk_done_i) begin
                        if (last_q) begin
                            state     <= WAIT;
                            cs_active <= 1'b0;
                            wait_cnt  <= '0;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_data_o <= in_beat_i.data;
        end
    end

    // Chip select, one low bit at most
    always_comb begin
        for (int i = 0; i < `SPI_SLAVE_NUM; i++) begin
            cs_n_o[i] = ~(cs_active && (cfg_i.addr == `SPI_ADDR_WIDTH'(i)));
        end
    end

    // --------------------
    // Receive beat
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else if (sclk_done_i) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sclk_done_i) begin
            out_beat_o.data <= rx_data_i;
            out_beat_o.last <= last_q;
        end
    end

endmodule

//--- rtl/stream_reg_slice.sv
// Single-entry valid/ready register slice with a type-parameter payload

`timescale 1ns/1ns

module stream_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rstn_i,

    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,

    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    logic in_fire;

    // Room when empty or when the held entry leaves this cycle
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else if (in_fire) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            out_data_o <= in_data_i;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module spi_master_tb -f all.f -o Vspi_master_tb

out=$(./obj_dir/Vspi_master_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- verification/spi_master_props.sv
// SPI master properties on chip select, SCLK idle level and output stream hold, with bind

`timescale 1ns/1ns

module spi_master_props (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        m_valid_o,
    input  spi_stream_pkg::rx_beat_t    m_beat_o,
    input  logic                        m_ready_i,
    input  spi_cfg_pkg::spi_cfg_t       cfg_i,
    input  spi_cfg_pkg::spi_pins_t      spi_o
);

    // Number of failed assertions
    int fail_count = 0;

    // One chip select low at most
    cs_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(~spi_o.cs_n))
        else begin
            $error("More than one chip select low: %b", spi_o.cs_n);
            fail_count++;
        end

    // Deselected SCLK rests at cpol, one cycle after cpol settles
    sclk_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (&spi_o.cs_n && $stable(cfg_i.cpol)) |-> (spi_o.sclk == cfg_i.cpol))
        else begin
            $error("SCLK %b differs from cpol %b while deselected", spi_o.sclk, cfg_i.cpol);
            fail_count++;
        end

    // Stalled output beat holds
    m_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o)))
        else begin
            $error("Output beat dropped or changed while stalled");
            fail_count++;
        end

endmodule

bind spi_master_top spi_master_props u_props (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .m_valid_o (m_valid_o),
    .m_beat_o  (m_beat_o),
    .m_ready_i (m_ready_i),
    .cfg_i     (cfg_i),
    .spi_o     (spi_o)
);

//--- verification/spi_master_tb.sv
// SPI master testbench with stimulus table, MOSI loopback, LCG data, checks and watchdog

`timescale 1ns/1ns

`include "spi_defs.svh"

module spi_master_tb;

    import spi_cfg_pkg::*;
    import spi_stream_pkg::*;

    localparam logic [31:0] SEED      = 32'h5a3f_0f67;
    localparam int          NUM_CASES = 7;

    typedef struct {
        string name;
        logic  cpol;
        logic  cpha;
        int    divider;
        int    wait_time;
        int    addr;
        int    words;
    } case_t;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      s_valid_i;
    tx_beat_t  s_beat_i;
    logic      s_ready_o;
    logic      m_valid_o;
    rx_beat_t  m_beat_o;
    logic      m_ready_i;
    spi_cfg_t  cfg_i;
    spi_pins_t spi_o;
    logic      miso_i;

    case_t     cases [NUM_CASES];
    rx_beat_t  exp_q [$];
    string     name_q [$];
    int        pkt_q [$];
    int        errors = 0;
    int        checks = 0;
    int        limit_cycles = 0;

    // Chip-select monitor state
    logic      cs_low = 1'b0;
    logic      had_gap = 1'b0;
    logic      sclk_prev = 1'b0;
    int        sclk_edges = 0;
    int        cycle = 0;
    int        rise_cycle = 0;
    int        rise_wait = 0;

    always #20 clk_i = ~clk_i;

    // Slave replaced by a wire from MOSI to MISO
    assign miso_i = spi_o.mosi;

    spi_master_top dut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .s_valid_i (s_valid_i),
        .s_beat_i  (s_beat_i),
        .s_ready_o (s_ready_o),
        .m_valid_o (m_valid_o),
        .m_beat_o  (m_beat_o),
        .m_ready_i (m_ready_i),
        .cfg_i     (cfg_i),
        .spi_o     (spi_o),
        .miso_i    (miso_i)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic spi_cfg_t to_cfg(input case_t c);
        spi_cfg_t cfg;
        cfg.cpol      = c.cpol;
        cfg.cpha      = c.cpha;
        cfg.divider   = c.divider[`SPI_DIV_WIDTH-1:0];
        cfg.wait_time = c.wait_time[`SPI_WAIT_WIDTH-1:0];
        cfg.addr      = c.addr[`SPI_ADDR_WIDTH-1:0];
        return cfg;
    endfunction

    // Expected SCLK and chip selects for a row
    function automatic spi_pins_t expected_pins(input case_t c, input logic selected);
        spi_pins_t pins;
        pins.sclk = c.cpol;
        pins.mosi = 1'b0;
        pins.cs_n = '1;
        if (selected) begin
            pins.cs_n[c.addr] = 1'b0;
        end
        return pins;
    endfunction

    task automatic check_rx_beat(input string name, input rx_beat_t exp, input rx_beat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: rx beat expected data %h last %b, got data %h last %b",
                     name, exp.data, exp.last, act.data, act.last);
        end
    endtask

    // MOSI is free while deselected, so only SCLK and chip selects count
    task automatic check_pins(input string name, input spi_pins_t exp, input spi_pins_t act,
                              input logic with_sclk);
        checks++;
        if (act.cs_n !== exp.cs_n || (with_sclk && act.sclk !== exp.sclk)) begin
            errors++;
            if (with_sclk) begin
                $display("[FAIL] %s: pins expected sclk %b cs_n %b, got sclk %b cs_n %b",
                         name, exp.sclk, exp.cs_n, act.sclk, act.cs_n);
            end else begin
                $display("[FAIL] %s: cs_n expected %b, got %b", name, exp.cs_n, act.cs_n);
            end
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: %s expected %b, got %b", name, what, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s: sclk transitions expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic send_beat(input tx_beat_t beat);
        @(negedge clk_i);
        s_valid_i = 1'b1;
        s_beat_i  = beat;
        @(posedge clk_i);
        while (!s_ready_o) begin
            @(posedge clk_i);
        end
    endtask

    // All results back, then the post-packet wait runs out
    task automatic drain(input case_t c);
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (c.wait_time + 4) @(negedge clk_i);
        check_pins(c.name, expected_pins(c, 1'b0), spi_o, 1'b1);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [31:0] data_state;
        tx_beat_t    beat;
        rx_beat_t    exp;
        int          limit;
        cases[0] = '{"mode0_a", 1'b0, 1'b0, 4, 3, 0, 4};
        cases[1] = '{"mode0_b", 1'b0, 1'b0, 4, 3, 0, 2};
        cases[2] = '{"mode1", 1'b0, 1'b1, 6, 5, 1, 3};
        cases[3] = '{"mode2", 1'b1, 1'b0, 4, 2, 2, 5};
        cases[4] = '{"mode3_a", 1'b1, 1'b1, 8, 1, 3, 3};
        cases[5] = '{"mode3_b", 1'b1, 1'b1, 8, 1, 3, 1};
        cases[6] = '{"slow0", 1'b0, 1'b0, 12, 4, 1, 2};
        limit = 0;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += cases[i].words *
                     (cases[i].divider * `SPI_DATA_WIDTH + cases[i].wait_time + 10);
        end
        data_state   = SEED;
        rstn_i       = 1'b0;
        s_valid_i    = 1'b0;
        s_beat_i     = '0;
        cfg_i        = to_cfg(cases[0]);
        limit_cycles = 2 * limit;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        check_pins("reset", expected_pins(cases[0], 1'b0), spi_o, 1'b1);
        check_flag("reset", "m_valid", 1'b0, m_valid_o);
        check_flag("reset", "s_ready", 1'b1, s_ready_o);
        for (int r = 0; r < NUM_CASES; r++) begin
            // Same settings follow straight on and exercise the packet gap
            if (r > 0 && to_cfg(cases[r]) != cfg_i) begin
                drain(cases[r-1]);
                @(negedge clk_i);
                cfg_i = to_cfg(cases[r]);
            end
            pkt_q.push_back(r);
            for (int w = 0; w < cases[r].words; w++) begin
                data_state = lcg_step(data_state);
                beat.data  = data_state[23:16];
                beat.last  = (w == cases[r].words - 1);
                exp.data   = beat.data;
                exp.last   = beat.last;
                exp_q.push_back(exp);
                name_q.push_back(cases[r].name);
                send_beat(beat);
            end
            @(negedge clk_i);
            s_valid_i = 1'b0;
        end
        drain(cases[NUM_CASES-1]);
        if (pkt_q.size() != 0) begin
            errors++;
            $display("%0d packets were sent without chip select going low", pkt_q.size());
        end
        errors += dut.u_props.fail_count;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // --------------------
    // Output side
    // --------------------
    initial begin
        logic [31:0] ready_state;
        rx_beat_t    exp;
        string       name;
        ready_state = SEED;
        m_ready_i   = 1'b0;
        wait (rstn_i === 1'b1);
        forever begin
            @(negedge clk_i);
            ready_state = lcg_step(ready_state);
            // Stall about one cycle in four
            m_ready_i = (ready_state[31:30] != 2'b00);
            @(posedge clk_i);
            if (m_valid_o && m_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output beat %h arrived with nothing outstanding", m_beat_o.data);
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_rx_beat(name, exp, m_beat_o);
                end
            end
        end
    end

    // Chip-select decode, SCLK periods per packet and gap between packets
    always @(negedge clk_i) begin
        int row;
        if (rstn_i) begin
            if (!(&spi_o.cs_n)) begin
                if (!cs_low) begin
                    cs_low     = 1'b1;
                    sclk_edges = 0;
                    if (had_gap && (cycle - rise_cycle) < rise_wait) begin
                        errors++;
                        $display("Chip select high for only %0d cycles between packets, need %0d",
                                 cycle - rise_cycle, rise_wait);
                    end
                end
                if (spi_o.sclk != sclk_prev) begin
                    sclk_edges++;
                end
                if (pkt_q.size() == 0) begin
                    errors++;
                    $display("Chip select went low with no packet sent");
                end else begin
                    check_pins(cases[pkt_q[0]].name, expected_pins(cases[pkt_q[0]], 1'b1),
                               spi_o, 1'b0);
                end
            end else if (cs_low) begin
                cs_low     = 1'b0;
                had_gap    = 1'b1;
                rise_cycle = cycle;
                if (pkt_q.size() != 0) begin
                    row       = pkt_q.pop_front();
                    rise_wait = cases[row].wait_time;
                    check_count(cases[row].name, cases[row].words * 2 * `SPI_DATA_WIDTH,
                                sclk_edges);
                end
            end
            sclk_prev = spi_o.sclk;
            cycle++;
        end
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Timeout after %0d cycles, transfers did not complete", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
